// ==== conv1d.f ====
conv1d_pkg.sv
conv1d_apb_regs.sv
conv1d_seq.sv
conv1d_datapath.sv
conv1d_top.sv
conv1d_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the conv1d testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module conv1d_tb \
  -f conv1d.f -o conv1d_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/conv1d_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// ==== conv1d_tb.sv ====
`timescale 1ns/1ps

module conv1d_tb;

  import conv1d_pkg::*;

  localparam int    CLK_PERIOD = 100;
  localparam int    RUN_CYCLES = (6 + 4 * 12 + 20) + (6 + 4 * 1 + 20) + (6 + 4 * 0 + 20);
  localparam word_t ADDR_MASK  = (32'd1 << ADDR_W) - 32'd1;
  localparam word_t COUNT_MASK = (32'd1 << COUNT_W) - 32'd1;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;
  mem_req_t    mem_req;
  word_t       mem_rdata;
  logic        done;

  word_t       mem [128];
  word_t       exp_mem [128];
  addr_t       exp_addr_q [$];
  word_t       exp_data_q [$];
  logic [15:0] lfsr = 16'd19381;
  int          done_rises = 0;
  int          rises_before;
  logic        err;
  word_t       rdata;
  taps_t       taps;

  conv1d_top u_conv1d_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .mem_req_o   (mem_req),
    .mem_rdata_i (mem_rdata),
    .done_o      (done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------
  // Checks and reference model
  // ------------------------------
  task automatic compare_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_with_reason(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[DATA_W-2:0], lfsr[0]};
    end
    return val;
  endfunction

  // Output n is the sum of x[n+k] * h[k] over the low byte of each word
  function automatic word_t conv_ref(input taps_t h, input addr_t src, input int n);
    word_t acc;
    acc = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc = acc + word_t'(exp_mem[addr_t'(src + n + k)][SAMPLE_W-1:0]) * word_t'(h[k]);
    end
    return acc;
  endfunction

  // ------------------------------
  // APB access
  // ------------------------------
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input word_t wdata,
                          output word_t data, output logic slverr);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    data   = prdata;
    slverr = pslverr;
    compare_value("pready_o", word_t'(pready), 32'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input word_t data);
    apb_xfer(1'b1, addr, data, rdata, err);
    compare_value("pslverr_o", word_t'(err), 32'd0);
  endtask

  task automatic read_expect(input logic [7:0] addr, input string name, input word_t exp);
    apb_xfer(1'b0, addr, 32'd0, rdata, err);
    compare_value({name, " pslverr_o"}, word_t'(err), 32'd0);
    compare_value(name, rdata, exp);
  endtask

  task automatic expect_config(input word_t t, input word_t s, input word_t d, input word_t c);
    read_expect(REG_TAPS, "TAPS", t);
    read_expect(REG_SRC, "SRC", s);
    read_expect(REG_DST, "DST", d);
    read_expect(REG_COUNT, "COUNT", c);
  endtask

  // ------------------------------
  // Runs
  // ------------------------------
  task automatic prepare_run(input addr_t src, input addr_t dst, input int count);
    word_t v;
    taps = taps_t'(rand_bits(32));
    for (int i = 0; i < count + NUM_TAPS - 1; i++) begin
      v = rand_bits(32);
      mem[addr_t'(src + i)]     = v;
      exp_mem[addr_t'(src + i)] = v;
    end
    for (int n = 0; n < count; n++) begin
      v = conv_ref(taps, src, n);
      exp_addr_q.push_back(addr_t'(dst + n));
      exp_data_q.push_back(v);
      exp_mem[addr_t'(dst + n)] = v;
    end
    write_reg(REG_TAPS, word_t'(taps));
    write_reg(REG_SRC, word_t'(src));
    write_reg(REG_DST, word_t'(dst));
    write_reg(REG_COUNT, word_t'(count));
    rises_before = done_rises;
  endtask

  // Done drops at the accepted start and rises again at the end of the run
  task automatic verify_run();
    while (done) @(negedge clk);
    while (!done) @(negedge clk);
    read_expect(REG_STATUS, "STATUS", 32'd2);
    compare_value("done_o rises", word_t'(done_rises - rises_before), 32'd1);
    compare_value("pending writes", word_t'(exp_addr_q.size()), 32'd0);
    for (int i = 0; i < 128; i++) begin
      compare_value($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
    end
  endtask

  // ------------------------------
  // Memory model and monitors
  // ------------------------------
  initial begin : memory_model
    mem_req_t seen;
    mem_rdata = '0;
    forever begin
      @(negedge clk);
      seen = mem_req;
      @(posedge clk);
      #1;
      if (seen.req && seen.we) begin
        mem[seen.addr] = seen.wdata;
      end else if (seen.req) begin
        mem_rdata = mem[seen.addr];
      end
    end
  end

  initial begin : write_checker
    forever begin
      @(negedge clk);
      if (mem_req.req && mem_req.we) begin
        if (exp_addr_q.size() == 0) begin
          stop_with_reason("DUT wrote to memory when no write was expected");
        end else begin
          compare_value("mem_req_o.addr", word_t'(mem_req.addr), word_t'(exp_addr_q.pop_front()));
          compare_value("mem_req_o.wdata", mem_req.wdata, exp_data_q.pop_front());
        end
      end
    end
  end

  initial begin : done_monitor
    logic done_prev;
    done_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (done && !done_prev) begin
        done_rises++;
      end
      done_prev = done;
    end
  end

  initial begin : watchdog
    #(2 * RUN_CYCLES * CLK_PERIOD);
    stop_with_reason("Timeout: the test did not finish in the allowed time");
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main_test
    rst_n   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int i = 0; i < 128; i++) begin
      mem[i]     = (word_t'(i) * 32'h0101_0101) ^ 32'h5A00_C300;
      exp_mem[i] = mem[i];
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b0;

    // Reset values, readback and masking
    read_expect(REG_STATUS, "STATUS", 32'd0);
    expect_config(32'd0, 32'd0, 32'd0, 32'd0);
    write_reg(REG_TAPS, 32'hA5C3_1E77);
    write_reg(REG_SRC, 32'hFFFF_FFFF);
    write_reg(REG_DST, 32'h0000_01D2);
    write_reg(REG_COUNT, 32'hFFFF_FF8C);
    expect_config(32'hA5C3_1E77, 32'hFFFF_FFFF & ADDR_MASK, 32'h0000_01D2 & ADDR_MASK,
                  32'hFFFF_FF8C & COUNT_MASK);

    // Unmapped offsets
    apb_xfer(1'b1, 8'h18, 32'h1234_5678, rdata, err);
    compare_value("pslverr_o", word_t'(err), 32'd1);
    apb_xfer(1'b0, 8'h1C, 32'd0, rdata, err);
    compare_value("pslverr_o", word_t'(err), 32'd1);
    compare_value("prdata_o", rdata, 32'd0);
    expect_config(32'hA5C3_1E77, 32'hFFFF_FFFF & ADDR_MASK, 32'h0000_01D2 & ADDR_MASK,
                  32'hFFFF_FF8C & COUNT_MASK);

    // Twelve outputs, with a second start while busy
    prepare_run(7'h10, 7'h40, 12);
    write_reg(REG_CTRL, 32'd1);
    read_expect(REG_STATUS, "STATUS", 32'd1);
    write_reg(REG_CTRL, 32'd1);
    verify_run();

    // One output with new taps and bases
    prepare_run(7'h60, 7'h05, 1);
    write_reg(REG_CTRL, 32'd1);
    verify_run();

    // Empty run
    prepare_run(7'h20, 7'h70, 0);
    write_reg(REG_CTRL, 32'd1);
    verify_run();

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== conv1d_top.sv ====
`timescale 1ns/1ps

module conv1d_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [7:0]           paddr_i,
  input  conv1d_pkg::word_t    pwdata_i,
  output conv1d_pkg::word_t    prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  output conv1d_pkg::mem_req_t mem_req_o,
  input  conv1d_pkg::word_t    mem_rdata_i,
  output logic                 done_o
);

  import conv1d_pkg::*;

  conv_cfg_t  cfg;
  conv_stat_t stat;
  logic       sample_load;
  logic       sum_load;
  word_t      sum;

  conv1d_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .stat_i    (stat),
    .cfg_o     (cfg),
    .done_o    (done_o)
  );

  conv1d_seq u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_i         (cfg),
    .stat_o        (stat),
    .mem_req_o     (mem_req_o),
    .sample_load_o (sample_load),
    .sum_load_o    (sum_load),
    .sum_i         (sum)
  );

  // Samples sit in the low byte of each word
  conv1d_datapath u_dp (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_load_i (sample_load),
    .sample_i      (mem_rdata_i[SAMPLE_W-1:0]),
    .taps_i        (cfg.taps),
    .sum_load_i    (sum_load),
    .sum_o         (sum)
  );

endmodule

// ==== conv1d_datapath.sv ====
`timescale 1ns/1ps

module conv1d_datapath (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sample_load_i,
  input  conv1d_pkg::sample_t sample_i,
  input  conv1d_pkg::taps_t   taps_i,
  input  logic                sum_load_i,
  output conv1d_pkg::word_t   sum_o
);

  import conv1d_pkg::*;

  // Entry 0 holds the oldest sample
  sample_t [NUM_TAPS-1:0]                 win_q;
  logic    [NUM_TAPS-1:0][2*SAMPLE_W-1:0] prod;
  word_t                                  sum_lo;
  word_t                                  sum_hi;
  word_t                                  sum_d;
  word_t                                  sum_q;

  // ------------------------------
  // Sample window
  // ------------------------------
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      win_q <= '0;
    end else if (sample_load_i) begin
      // New sample enters at the top
      win_q <= {sample_i, win_q[NUM_TAPS-1:1]};
    end
  end

  // Four 8x8 multipliers
  always_comb begin
    for (int k = 0; k < NUM_TAPS; k++) begin
      prod[k] = win_q[k] * taps_i[k];
    end
  end

  // ------------------------------
  // Adder tree
  // ------------------------------
  assign sum_lo = word_t'(prod[0]) + word_t'(prod[1]);
  assign sum_hi = word_t'(prod[2]) + word_t'(prod[3]);
  assign sum_d  = sum_lo + sum_hi;

  always_ff @(posedge clk) begin
    if (sum_load_i) begin
      sum_q <= sum_d;
    end
  end

  assign sum_o = sum_q;

endmodule

// ==== conv1d_seq.sv ====
`timescale 1ns/1ps

module conv1d_seq (
  input  logic                   clk,
  input  logic                   rst_n,
  input  conv1d_pkg::conv_cfg_t  cfg_i,
  output conv1d_pkg::conv_stat_t stat_o,
  output conv1d_pkg::mem_req_t   mem_req_o,
  output logic                   sample_load_o,
  output logic                   sum_load_o,
  input  conv1d_pkg::word_t      sum_i
);

  import conv1d_pkg::*;

  seq_state_t         state_q;
  seq_state_t         state_d;
  addr_t              rd_addr_q;
  addr_t              wr_addr_q;
  logic [1:0]         fill_q;
  logic [COUNT_W-1:0] left_q;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cfg_i.start) begin
          // Nothing to compute so finish at once
          state_d = (cfg_i.out_count == '0) ? S_DONE : S_READ;
        end
      end
      S_READ: begin
        state_d = S_CAPTURE;
      end
      S_CAPTURE: begin
        // Fetch another sample until the window is full
        state_d = (fill_q != '0) ? S_READ : S_SUM;
      end
      S_SUM: begin
        state_d = S_WRITE;
      end
      S_WRITE: begin
        state_d = (left_q == COUNT_W'(1)) ? S_DONE : S_READ;
      end
      S_DONE: begin
        state_d = S_IDLE;
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  // ------------------------------
  // State and counters
  // ------------------------------
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      state_q   <= S_IDLE;
      rd_addr_q <= '0;
      wr_addr_q <= '0;
      fill_q    <= '0;
      left_q    <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        S_IDLE: begin
          if (cfg_i.start) begin
            rd_addr_q <= cfg_i.src_base;
            wr_addr_q <= cfg_i.dst_base;
            fill_q    <= 2'(NUM_TAPS - 1);
            left_q    <= cfg_i.out_count;
          end
        end
        S_READ: begin
          rd_addr_q <= rd_addr_q + addr_t'(1);
        end
        S_CAPTURE: begin
          if (fill_q != '0) begin
            fill_q <= fill_q - 2'd1;
          end
        end
        S_WRITE: begin
          wr_addr_q <= wr_addr_q + addr_t'(1);
          left_q    <= left_q - COUNT_W'(1);
        end
        default: ;
      endcase
    end
  end

  // Read data arrives the cycle after S_READ
  assign sample_load_o = (state_q == S_CAPTURE);
  assign sum_load_o    = (state_q == S_SUM);

  assign mem_req_o.req   = (state_q == S_READ) || (state_q == S_WRITE);
  assign mem_req_o.we    = (state_q == S_WRITE);
  assign mem_req_o.addr  = (state_q == S_WRITE) ? wr_addr_q : rd_addr_q;
  assign mem_req_o.wdata = sum_i;

  assign stat_o.busy = (state_q != S_IDLE);
  assign stat_o.done = (state_q == S_DONE);

endmodule

// ==== conv1d_apb_regs.sv ====
`timescale 1ns/1ps

module conv1d_apb_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [7:0]             paddr_i,
  input  conv1d_pkg::word_t      pwdata_i,
  output conv1d_pkg::word_t      prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  conv1d_pkg::conv_stat_t stat_i,
  output conv1d_pkg::conv_cfg_t  cfg_o,
  output logic                   done_o
);

  import conv1d_pkg::*;

  logic               access;
  logic               wr_en;
  apb_status_e        resp;
  taps_t              taps_q;
  addr_t              src_q;
  addr_t              dst_q;
  logic [COUNT_W-1:0] count_q;
  logic               start_q;
  logic               done_q;

  // Second cycle of a transfer
  assign access = psel_i & penable_i;

  always_comb begin
    case (paddr_i)
      REG_CTRL, REG_STATUS, REG_TAPS, REG_SRC, REG_DST, REG_COUNT: resp = RESP_OK;
      default: resp = RESP_BAD_ADDR;
    endcase
  end

  assign wr_en     = access & pwrite_i & (resp == RESP_OK);
  assign pready_o  = 1'b1;
  assign pslverr_o = access & (resp == RESP_BAD_ADDR);

  // ------------------------------
  // Configuration registers
  // ------------------------------
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      taps_q  <= '0;
      src_q   <= '0;
      dst_q   <= '0;
      count_q <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        REG_TAPS:  taps_q  <= taps_t'(pwdata_i);
        REG_SRC:   src_q   <= pwdata_i[ADDR_W-1:0];
        REG_DST:   dst_q   <= pwdata_i[ADDR_W-1:0];
        REG_COUNT: count_q <= pwdata_i[COUNT_W-1:0];
        default: ;
      endcase
    end
  end

  // Start pulse and sticky done
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // Dropped while a run is still going
      start_q <= wr_en && (paddr_i == REG_CTRL) && pwdata_i[0] && !stat_i.busy;
      if (stat_i.done) begin
        done_q <= 1'b1;
      end else if (start_q) begin
        done_q <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Readback
  // ------------------------------
  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      REG_STATUS: prdata_o = {30'b0, done_q, stat_i.busy};
      REG_TAPS:   prdata_o = word_t'(taps_q);
      REG_SRC:    prdata_o = word_t'(src_q);
      REG_DST:    prdata_o = word_t'(dst_q);
      REG_COUNT:  prdata_o = word_t'(count_q);
      default: ;
    endcase
  end

  assign cfg_o.start     = start_q;
  assign cfg_o.src_base  = src_q;
  assign cfg_o.dst_base  = dst_q;
  assign cfg_o.out_count = count_q;
  assign cfg_o.taps      = taps_q;
  assign done_o          = done_q;

endmodule

// ==== conv1d_pkg.sv ====
package conv1d_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int ADDR_W   = 7;
  localparam int DATA_W   = 32;
  localparam int SAMPLE_W = 8;
  localparam int NUM_TAPS = 4;
  localparam int COUNT_W  = 7;

  // APB register map as byte offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_STATUS = 8'h04;
  localparam logic [7:0] REG_TAPS   = 8'h08;
  localparam logic [7:0] REG_SRC    = 8'h0C;
  localparam logic [7:0] REG_DST    = 8'h10;
  localparam logic [7:0] REG_COUNT  = 8'h14;

  // ------------------------------
  // Types
  // ------------------------------
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Tap k lives in byte k
  typedef sample_t [NUM_TAPS-1:0] taps_t;

  typedef struct packed {
    logic               start;
    addr_t              src_base;
    addr_t              dst_base;
    logic [COUNT_W-1:0] out_count;
    taps_t              taps;
  } conv_cfg_t;

  typedef struct packed {
    logic busy;
    logic done;
  } conv_stat_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,
    S_CAPTURE,
    S_SUM,
    S_WRITE,
    S_DONE
  } seq_state_t;

  typedef enum logic {
    RESP_OK,
    RESP_BAD_ADDR
  } apb_status_e;

endpackage
